/* build.f */
+incdir+logic
logic/pctrl_pkg.sv
logic/pctrl_reg_block.sv
logic/clk_enable_gen.sv
logic/periph_reset_seq.sv
logic/platform_ctrl_top.sv
dv/platform_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the platform controller testbench with Verilator.
# All output goes to sim.log, and pass or fail is taken from that log.
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal -f build.f --top-module platform_ctrl_tb \
  -Mdir obj_dir -o platform_ctrl_sim > sim.log 2>&1 &&
./obj_dir/platform_ctrl_sim >> sim.log 2>&1
grep -qx "Regression passed" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }

/* dv/pctrl_trace.txt */
# write addr data | read addr expect   (hex operands)
# clken idx window count | resetwait idx delay cycles | quiet cycles | sysreq | lockup | wdog
read 0 110
read 3 110
read 5 0
read 6 0
read 7 0
write 2 ffffffff
read 2 117
read 4 0
write 6 1
read 6 1
clken 2 256 2
write 1 113
clken 1 256 32
clken 0 512 512
write 3 105
clken 3 256 0
write 2 110
write 1 110
write 3 110
write 4 6
resetwait 1 1 4
read 5 6
write 5 f
read 5 0
write 1 010
sysreq
resetwait 0 1 4
read 5 d
write 5 f
write 6 0
lockup
quiet 12
read 5 0
write 6 1
lockup
resetwait 2 1 4
read 5 d
write 5 f
wdog
resetwait 3 1 4
read 5 d

/* dv/platform_ctrl_tb.sv */
//--------------------------------------
// Trace driven testbench with clock,
// reset, drivers, checker and summary
//--------------------------------------
`include "pctrl_defines.svh"

module platform_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import pctrl_pkg::*;

  localparam int NUM          = `PCTRL_NUM_PERIPH;
  localparam int RISE_TIMEOUT = 32;
  localparam int HOLD_TIMEOUT = 64;

  logic                     master_clk;
  logic                     reset;
  reg_access_t              reg_access;
  reset_req_t               reset_req;
  logic [`PCTRL_DATA_W-1:0] rdata;
  logic [NUM-1:0]           clken;
  logic [NUM-1:0]           periph_reset;
  int                       check_cnt;
  int                       error_cnt;
  // Timeouts and trace problems
  int                       fail_cnt;

  platform_ctrl_top u_platform_ctrl_top (
    .master_clk   (master_clk),
    .reset        (reset),
    .reg_access   (reg_access),
    .reset_req    (reset_req),
    .rdata        (rdata),
    .clken        (clken),
    .periph_reset (periph_reset)
  );

  initial begin
    master_clk = 1'b0;
    forever begin
      #4 master_clk = ~master_clk;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  //--------------------------------------
  // Bus and request drivers
  //--------------------------------------
  task automatic reg_write(input logic [`PCTRL_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge master_clk);
    reg_access <= '{wr_en: 1'b1, rd_en: 1'b0, addr: addr, wdata: data};
    @(posedge master_clk);
    reg_access <= '0;
  endtask

  task automatic reg_read(input logic [`PCTRL_ADDR_W-1:0] addr, input logic [31:0] expected);
    @(posedge master_clk);
    reg_access <= '{wr_en: 1'b0, rd_en: 1'b1, addr: addr, wdata: '0};
    @(posedge master_clk);
    reg_access <= '0;
    // rdata was loaded on the edge that saw rd_en
    @(negedge master_clk);
    check($sformatf("rdata[0x%0h]", addr), rdata, expected);
  endtask

  task automatic pulse_request(input reset_req_t req);
    @(posedge master_clk);
    reset_req <= req;
    @(posedge master_clk);
    reset_req <= '0;
  endtask

  //--------------------------------------
  // Output monitors
  //--------------------------------------
  task automatic count_clken(input int idx, input int window, input int expected);
    int pulses;
    pulses = 0;
    // A new divide setting needs two edges to reach the qualifier
    repeat (2) @(posedge master_clk);
    for (int c = 0; c < window; c++) begin
      @(negedge master_clk);
      if (clken[idx]) begin
        pulses++;
      end
    end
    check($sformatf("clken[%0d] pulses", idx), pulses, expected);
  endtask

  task automatic wait_reset(input int idx, input int delay, input int cycles);
    int waited;
    int held;
    waited = 0;
    held = 0;
    @(negedge master_clk);
    while (!periph_reset[idx] && waited < RISE_TIMEOUT) begin
      @(negedge master_clk);
      waited++;
    end
    if (!periph_reset[idx]) begin
      fail_cnt++;
      $display("timeout: periph_reset[%0d] never asserted", idx);
    end else begin
      check($sformatf("periph_reset[%0d] delay", idx), waited, delay);
      while (periph_reset[idx] && held < HOLD_TIMEOUT) begin
        held++;
        @(negedge master_clk);
      end
      if (periph_reset[idx]) begin
        fail_cnt++;
        $display("timeout: periph_reset[%0d] never released", idx);
      end else begin
        check($sformatf("periph_reset[%0d] cycles", idx), held, cycles);
      end
    end
  endtask

  task automatic expect_quiet(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge master_clk);
      check("periph_reset", 32'(periph_reset), 32'h0);
    end
  endtask

  task automatic run_command(input string line);
    string       word;
    logic [31:0] a;
    logic [31:0] d;
    int          i;
    int          w;
    int          x;
    reset_req_t  req;
    req = '0;
    if ($sscanf(line, "%s", word) < 1 || word.getc(0) == "#") begin
      return;
    end
    if (word == "write" && $sscanf(line, "%s %h %h", word, a, d) == 3) begin
      reg_write(a[`PCTRL_ADDR_W-1:0], d);
    end else if (word == "read" && $sscanf(line, "%s %h %h", word, a, d) == 3) begin
      reg_read(a[`PCTRL_ADDR_W-1:0], d);
    end else if (word == "clken" && $sscanf(line, "%s %d %d %d", word, i, w, x) == 4) begin
      count_clken(i, w, x);
    end else if (word == "resetwait" && $sscanf(line, "%s %d %d %d", word, i, w, x) == 4) begin
      wait_reset(i, w, x);
    end else if (word == "quiet" && $sscanf(line, "%s %d", word, i) == 2) begin
      expect_quiet(i);
    end else if (word == "sysreq" || word == "lockup" || word == "wdog") begin
      req.sys_reset_req  = (word == "sysreq");
      req.lockup         = (word == "lockup");
      req.wdog_reset_req = (word == "wdog");
      pulse_request(req);
    end else begin
      fail_cnt++;
      $display("trace line not understood: %s", line);
    end
  endtask

  //--------------------------------------
  // Main sequence
  //--------------------------------------
  initial begin
    int    fd;
    int    held;
    string line;
    reset      = 1'b1;
    reg_access = '0;
    reset_req  = '0;
    check_cnt  = 0;
    error_cnt  = 0;
    fail_cnt   = 0;
    held       = 0;
    @(posedge master_clk);
    @(negedge master_clk);
    check("clken", 32'(clken), 32'h0);
    check("periph_reset", 32'(periph_reset), 32'(4'hf));
    @(posedge master_clk);
    reset <= 1'b0;
    // Post-reset hold on every peripheral
    @(negedge master_clk);
    while (periph_reset == '1 && held < HOLD_TIMEOUT) begin
      held++;
      @(negedge master_clk);
    end
    if (periph_reset == '1) begin
      fail_cnt++;
      $display("timeout: periph_reset never released after the global reset");
    end else begin
      check("post-reset hold cycles", held, `PCTRL_RESET_HOLD);
      check("periph_reset", 32'(periph_reset), 32'h0);
    end
    fd = $fopen("dv/pctrl_trace.txt", "r");
    if (fd == 0) begin
      fail_cnt++;
      $display("could not open the trace file dv/pctrl_trace.txt");
    end else begin
      while (!$feof(fd) && fail_cnt == 0) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          run_command(line);
        end
      end
      $fclose(fd);
    end
    $display("checks %0d, mismatches %0d, other failures %0d", check_cnt, error_cnt, fail_cnt);
    if (error_cnt == 0 && fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* logic/platform_ctrl_top.sv */
//--------------------------------------
// Platform controller top level
//--------------------------------------
`include "pctrl_defines.svh"

module platform_ctrl_top (
  input  logic                         master_clk,
  input  logic                         reset,
  input  pctrl_pkg::reg_access_t       reg_access,
  input  pctrl_pkg::reset_req_t        reset_req,
  output logic [`PCTRL_DATA_W-1:0]     rdata,
  output logic [`PCTRL_NUM_PERIPH-1:0] clken,
  output logic [`PCTRL_NUM_PERIPH-1:0] periph_reset
);

  import pctrl_pkg::*;

  periph_cfg_array_t              periph_cfg;
  logic [`PCTRL_NUM_PERIPH-1:0]   soft_req;
  logic [`PCTRL_NUM_PERIPH-1:0]   sys_req;
  logic [`PCTRL_NUM_PERIPH-1:0]   ack;

  //--------------------------------------
  // Register block
  //--------------------------------------
  pctrl_reg_block u_reg_block (
    .master_clk (master_clk),
    .reset      (reset),
    .reg_access (reg_access),
    .reset_req  (reset_req),
    .ack        (ack),
    .rdata      (rdata),
    .periph_cfg (periph_cfg),
    .soft_req   (soft_req),
    .sys_req    (sys_req)
  );

  //--------------------------------------
  // Clock qualifiers
  //--------------------------------------
  clk_enable_gen u_clk_enable_gen (
    .master_clk (master_clk),
    .reset      (reset),
    .periph_cfg (periph_cfg),
    .clken      (clken)
  );

  //--------------------------------------
  // Reset sequencers
  //--------------------------------------
  // One per peripheral, same index as the config words
  for (genvar i = 0; i < `PCTRL_NUM_PERIPH; i++) begin : g_reset_seq
    periph_reset_seq #(
      .HOLD_CYCLES (`PCTRL_RESET_HOLD)
    ) u_periph_reset_seq (
      .master_clk   (master_clk),
      .reset        (reset),
      .soft_req     (soft_req[i]),
      .sys_req      (sys_req[i]),
      .periph_reset (periph_reset[i]),
      .ack          (ack[i])
    );
  end

endmodule

/* logic/periph_reset_seq.sv */
//--------------------------------------
// Reset hold counter and ack pulse for
// one peripheral
//--------------------------------------
`include "pctrl_defines.svh"

module periph_reset_seq #(
  parameter int HOLD_CYCLES = `PCTRL_RESET_HOLD
) (
  input  logic master_clk,
  input  logic reset,
  input  logic soft_req,
  input  logic sys_req,
  output logic periph_reset,
  output logic ack
);

  import pctrl_pkg::*;

  localparam int CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(HOLD_CYCLES - 1);

  seq_state_t       state;
  logic [CNT_W-1:0] hold_cnt;
  logic             ack_pending;
  logic             trigger;

  assign trigger = soft_req | sys_req;

  // Peripheral sits in reset for the whole hold state
  assign periph_reset = (state == SEQ_HOLD);

  //--------------------------------------
  // Hold FSM
  //--------------------------------------
  always_ff @(posedge master_clk) begin
    if (reset) begin
      // Post-reset hold, released without an ack
      state       <= SEQ_HOLD;
      hold_cnt    <= CNT_LOAD;
      ack_pending <= 1'b0;
      ack         <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (trigger) begin
            state       <= SEQ_HOLD;
            hold_cnt    <= CNT_LOAD;
            ack_pending <= 1'b1;
          end
        end
        SEQ_HOLD: begin
          // Requests while holding are dropped
          if (hold_cnt == '0) begin
            state       <= SEQ_IDLE;
            ack         <= ack_pending;
            ack_pending <= 1'b0;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
      endcase
    end
  end

  // Ack only on the release edge of a requested hold
  a_ack_on_release : assert property (@(posedge master_clk) disable iff (reset)
    ack |-> ($past(periph_reset) && !periph_reset))
    else $error("ack outside the release cycle");

endmodule

/* logic/clk_enable_gen.sv */
//--------------------------------------
// Shared prescaler and per-peripheral
// clock qualifier pulses
//--------------------------------------
`include "pctrl_defines.svh"

module clk_enable_gen (
  input  logic                         master_clk,
  input  logic                         reset,
  input  pctrl_pkg::periph_cfg_array_t periph_cfg,
  output logic [`PCTRL_NUM_PERIPH-1:0] clken
);

  localparam int NUM = `PCTRL_NUM_PERIPH;
  localparam int PW  = `PCTRL_PRESCALE_W;

  logic [PW-1:0]  prescale;
  logic [NUM-1:0] clken_next;

  // Low div_sel bits of the prescaler
  function automatic logic [PW-1:0] div_mask(logic [`PCTRL_DIV_SEL_W-1:0] sel);
    return PW'((1 << sel) - 1);
  endfunction

  //--------------------------------------
  // Free-running prescaler
  //--------------------------------------
  always_ff @(posedge master_clk) begin
    if (reset) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  //--------------------------------------
  // Qualifier per peripheral
  //--------------------------------------
  // Fires once every 2**div_sel cycles while the gate is open
  always_comb begin
    for (int i = 0; i < NUM; i++) begin
      clken_next[i] = periph_cfg[i].gate_en &&
                      ((prescale & div_mask(periph_cfg[i].div_sel)) == '0);
    end
  end

  // Registered so the qualifiers stay low through reset
  always_ff @(posedge master_clk) begin
    if (reset) begin
      clken <= '0;
    end else begin
      clken <= clken_next;
    end
  end

  // A closed gate silences the qualifier from the next cycle on
  for (genvar i = 0; i < NUM; i++) begin : g_gate_check
    a_gate_closed : assert property (@(posedge master_clk) disable iff (reset)
      !$past(periph_cfg[i].gate_en) |-> !clken[i])
      else $error("clken[%0d] pulsed with gate_en low", i);
  end

endmodule

/* logic/pctrl_reg_block.sv */
//--------------------------------------
// Register file, reset request pulses,
// sticky ack status and sys reset merge
//--------------------------------------
`include "pctrl_defines.svh"

module pctrl_reg_block (
  input  logic                         master_clk,
  input  logic                         reset,
  input  pctrl_pkg::reg_access_t       reg_access,
  input  pctrl_pkg::reset_req_t        reset_req,
  input  logic [`PCTRL_NUM_PERIPH-1:0] ack,
  output logic [`PCTRL_DATA_W-1:0]     rdata,
  output pctrl_pkg::periph_cfg_array_t periph_cfg,
  output logic [`PCTRL_NUM_PERIPH-1:0] soft_req,
  output logic [`PCTRL_NUM_PERIPH-1:0] sys_req
);

  import pctrl_pkg::*;

  localparam int NUM = `PCTRL_NUM_PERIPH;
  localparam int DW  = `PCTRL_DATA_W;

  // Field positions inside a config word
  localparam int GATE_EN_BIT      = 4;
  localparam int SYS_RESET_EN_BIT = 8;

  // Divide by 1, clock running, follows system reset
  localparam periph_cfg_t CFG_DEFAULT = '{div_sel: '0, gate_en: 1'b1, sys_reset_en: 1'b1};

  logic           wr_rst_req;
  logic           wr_rst_stat;
  logic           wr_ctrl;
  logic           lockup_reset_en;
  logic [NUM-1:0] rst_stat;
  logic [NUM-1:0] stat_clr;
  logic           sys_merged;
  logic           sys_merged_q;
  logic           sys_rise;
  logic [DW-1:0]  rd_mux;

  function automatic logic [DW-1:0] cfg_to_word(periph_cfg_t cfg);
    logic [DW-1:0] word;
    word = '0;
    word[`PCTRL_DIV_SEL_W-1:0] = cfg.div_sel;
    word[GATE_EN_BIT]          = cfg.gate_en;
    word[SYS_RESET_EN_BIT]     = cfg.sys_reset_en;
    return word;
  endfunction

  function automatic periph_cfg_t word_to_cfg(logic [DW-1:0] word);
    periph_cfg_t cfg;
    cfg.div_sel      = word[`PCTRL_DIV_SEL_W-1:0];
    cfg.gate_en      = word[GATE_EN_BIT];
    cfg.sys_reset_en = word[SYS_RESET_EN_BIT];
    return cfg;
  endfunction

  //--------------------------------------
  // Write decode and register state
  //--------------------------------------
  assign wr_rst_req  = reg_access.wr_en &&
                       (reg_access.addr == `PCTRL_ADDR_W'(`PCTRL_REG_RST_REQ));
  assign wr_rst_stat = reg_access.wr_en &&
                       (reg_access.addr == `PCTRL_ADDR_W'(`PCTRL_REG_RST_STAT));
  assign wr_ctrl     = reg_access.wr_en &&
                       (reg_access.addr == `PCTRL_ADDR_W'(`PCTRL_REG_CTRL));

  // Write 1 to clear
  assign stat_clr = wr_rst_stat ? reg_access.wdata[NUM-1:0] : '0;

  always_ff @(posedge master_clk) begin
    if (reset) begin
      for (int i = 0; i < NUM; i++) begin
        periph_cfg[i] <= CFG_DEFAULT;
      end
      lockup_reset_en <= 1'b0;
      rst_stat        <= '0;
      soft_req        <= '0;
    end else begin
      for (int i = 0; i < NUM; i++) begin
        if (reg_access.wr_en &&
            (reg_access.addr == `PCTRL_ADDR_W'(`PCTRL_REG_CFG0 + i))) begin
          periph_cfg[i] <= word_to_cfg(reg_access.wdata);
        end
      end
      if (wr_ctrl) begin
        lockup_reset_en <= reg_access.wdata[0];
      end
      // A new ack wins over a clear in the same cycle
      rst_stat <= (rst_stat & ~stat_clr) | ack;
      // RST_REQ is not stored, each write gives a single pulse
      soft_req <= wr_rst_req ? reg_access.wdata[NUM-1:0] : '0;
    end
  end

  //--------------------------------------
  // System reset request merge
  //--------------------------------------
  assign sys_merged = reset_req.sys_reset_req | reset_req.wdog_reset_req |
                      (reset_req.lockup & lockup_reset_en);
  assign sys_rise   = sys_merged & ~sys_merged_q;

  always_ff @(posedge master_clk) begin
    if (reset) begin
      sys_merged_q <= 1'b0;
      sys_req      <= '0;
    end else begin
      sys_merged_q <= sys_merged;
      for (int i = 0; i < NUM; i++) begin
        sys_req[i] <= sys_rise & periph_cfg[i].sys_reset_en;
      end
    end
  end

  //--------------------------------------
  // Read path
  //--------------------------------------
  always_comb begin
    rd_mux = '0;
    for (int i = 0; i < NUM; i++) begin
      if (reg_access.addr == `PCTRL_ADDR_W'(`PCTRL_REG_CFG0 + i)) begin
        rd_mux = cfg_to_word(periph_cfg[i]);
      end
    end
    case (reg_access.addr)
      `PCTRL_ADDR_W'(`PCTRL_REG_RST_STAT): rd_mux = DW'(rst_stat);
      `PCTRL_ADDR_W'(`PCTRL_REG_CTRL):     rd_mux = DW'(lockup_reset_en);
      default: ;
    endcase
  end

  // Holds the last read value
  always_ff @(posedge master_clk) begin
    if (reset) begin
      rdata <= '0;
    end else if (reg_access.rd_en) begin
      rdata <= rd_mux;
    end
  end

  a_soft_req_single : assert property (@(posedge master_clk) disable iff (reset)
    (soft_req != '0) |=> (soft_req == '0))
    else $error("soft_req high in two consecutive cycles");

endmodule

/* logic/pctrl_pkg.sv */
//--------------------------------------
// Types shared by the platform controller
// and its testbench
//--------------------------------------
`include "pctrl_defines.svh"

package pctrl_pkg;

  // One peripheral's clock and reset configuration
  typedef struct packed {
    logic [`PCTRL_DIV_SEL_W-1:0] div_sel;
    logic                        gate_en;
    logic                        sys_reset_en;
  } periph_cfg_t;

  // Index 0 timer0, 1 timer1, 2 uart0, 3 wdog
  typedef periph_cfg_t [`PCTRL_NUM_PERIPH-1:0] periph_cfg_array_t;

  // Register port, one access per strobe
  typedef struct packed {
    logic                     wr_en;
    logic                     rd_en;
    logic [`PCTRL_ADDR_W-1:0] addr;
    logic [`PCTRL_DATA_W-1:0] wdata;
  } reg_access_t;

  // System level reset sources
  typedef struct packed {
    logic sys_reset_req;
    logic lockup;
    logic wdog_reset_req;
  } reset_req_t;

  // Reset sequencer FSM
  typedef enum logic {
    SEQ_IDLE,
    SEQ_HOLD
  } seq_state_t;

endpackage

/* logic/pctrl_defines.svh */
//--------------------------------------
// Platform controller sizes, register
// offsets and reset hold length
//--------------------------------------
`ifndef PCTRL_DEFINES_SVH
`define PCTRL_DEFINES_SVH

// Managed peripherals: timer0, timer1, uart0, wdog
`define PCTRL_NUM_PERIPH   4

// Register port
`define PCTRL_ADDR_W       4
`define PCTRL_DATA_W       32

// Clock qualifier generation
`define PCTRL_DIV_SEL_W    3
`define PCTRL_PRESCALE_W   8

// Cycles a peripheral is held in reset
`define PCTRL_RESET_HOLD   4

// Register offsets
// Config words sit at CFG0 + peripheral index
`define PCTRL_REG_CFG0     0
`define PCTRL_REG_RST_REQ  4
`define PCTRL_REG_RST_STAT 5
`define PCTRL_REG_CTRL     6

`endif
